//--- Makefile
# Verilator build for the cipher round controller

VERILATOR ?= verilator
TOP       ?= tb_cipher_round_ctrl
FILELIST  ?= cipher_round_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- cipher_round_ctrl.f
common/cipher_ctrl_pkg.sv
src/sp2v_chk.sv
round_fsm/round_fsm.sv
src/rail_combine.sv
src/cipher_round_ctrl.sv
tb/cipher_round_ctrl_chk.sv
tb/tb_cipher_round_ctrl.sv

//--- common/cipher_ctrl_pkg.sv
// Cipher round control definitions

package cipher_ctrl_pkg;

  ////////////////////
  // Sparse levels
  ////////////////////

  localparam int unsigned Sp2VWidth = 2;
  localparam int unsigned NumRails  = Sp2VWidth;  // One rail per sparse bit
  localparam int unsigned NumSp2VIn = 5;          // Sparse levels seen by the feeder

  // Bit i belongs to rail i and the upper bit is active low
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 2'b01,
    SP2V_LOW  = 2'b10
  } sp2v_e;

  // Raw per-rail bits of a logic high level
  localparam logic [Sp2VWidth-1:0] Sp2VLogicHigh = SP2V_HIGH;

  // Maps a true-polarity bit onto rail i of a sparse level and back again
  function automatic logic sp2v_rail_bit(logic b, int unsigned i);
    return b ~^ Sp2VLogicHigh[i];
  endfunction

  ////////////////////
  // Operation
  ////////////////////

  typedef enum logic [1:0] {
    CIPH_FWD = 2'b01,
    CIPH_INV = 2'b10
  } ciph_op_e;

  typedef enum logic [2:0] {
    KEY_128 = 3'b001,
    KEY_192 = 3'b010,
    KEY_256 = 3'b100
  } key_len_e;

  localparam int unsigned RndCtrWidth = 4;

  localparam logic [RndCtrWidth-1:0] Rounds128 = 4'd10;
  localparam logic [RndCtrWidth-1:0] Rounds192 = 4'd12;
  localparam logic [RndCtrWidth-1:0] Rounds256 = 4'd14;

  ////////////////////
  // Selectors and FSM
  ////////////////////

  typedef enum logic [2:0] {
    STATE_INIT  = 3'b001,
    STATE_ROUND = 3'b010,
    STATE_CLEAR = 3'b100
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  typedef enum logic [2:0] {
    IDLE   = 3'b000,
    INIT   = 3'b011,
    ROUND  = 3'b101,
    FINISH = 3'b110,
    ERROR  = 3'b111
  } ctrl_state_e;

  // Feeder to rail, all levels in true polarity
  typedef struct packed {
    logic     in_valid;
    logic     out_ready;
    logic     crypt_q;
    logic     dec_key_gen_q;
    logic     dec_key_gen;    // Sampled at acceptance
    ciph_op_e op;
    key_len_e key_len;
    logic     err;            // Sticky fault
  } rail_in_t;

  // Rail to combiner
  typedef struct packed {
    logic                   in_ready;
    logic                   out_valid;
    logic                   crypt_d;
    logic                   dec_key_gen_d;
    logic                   state_we;
    logic                   key_dec_we;
    logic                   alert;
    state_sel_e             state_sel;
    add_rk_sel_e            add_rk_sel;
    logic [RndCtrWidth-1:0] rnd_ctr;
  } rail_out_t;

  // Selectors towards the data path and key expansion
  typedef struct packed {
    state_sel_e             state_sel;
    add_rk_sel_e            add_rk_sel;
    ciph_op_e               key_expand_op;
    logic [RndCtrWidth-1:0] key_expand_round;
  } ctrl_sel_t;

endpackage

//--- round_fsm/round_fsm.sv
// Single rail round sequencer
`timescale 1ns/1ps

module round_fsm import cipher_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rail_in_t  rail_i,
  output rail_out_t rail_o
);

  ctrl_state_e            state_q;
  ctrl_state_e            state_d;
  logic [RndCtrWidth-1:0] rnd_ctr_q;
  logic [RndCtrWidth-1:0] rnd_ctr_d;
  logic [RndCtrWidth-1:0] rnd_lim_q;   // Total rounds of the current block
  logic [RndCtrWidth-1:0] rnd_lim_d;
  logic [RndCtrWidth-1:0] rnd_lim_new;
  logic [RndCtrWidth-1:0] rnd_last;
  logic                   len_err;
  logic                   op_err;

  ////////////////////
  // Configuration
  ////////////////////

  always_comb begin : decode_key_len
    len_err     = 1'b0;
    rnd_lim_new = Rounds128;
    case (rail_i.key_len)
      KEY_128: rnd_lim_new = Rounds128;
      KEY_192: rnd_lim_new = Rounds192;
      KEY_256: rnd_lim_new = Rounds256;
      default: len_err     = 1'b1;
    endcase
  end

  assign op_err   = !(rail_i.op inside {CIPH_FWD, CIPH_INV});
  assign rnd_last = rnd_lim_q - 1'b1;   // Last middle round

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin : fsm_comb
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    rnd_lim_d = rnd_lim_q;

    // Quiet defaults
    rail_o               = '0;
    rail_o.state_sel     = STATE_CLEAR;
    rail_o.add_rk_sel    = ADD_RK_INIT;
    rail_o.rnd_ctr       = rnd_ctr_q;
    rail_o.crypt_d       = rail_i.crypt_q;        // Hold
    rail_o.dec_key_gen_d = rail_i.dec_key_gen_q;  // Hold

    case (state_q)
      IDLE: begin
        rail_o.in_ready = 1'b1;
        if (rail_i.in_valid) begin
          if (op_err || len_err) begin
            state_d = ERROR;
          end else begin
            state_d              = INIT;
            rnd_ctr_d            = '0;
            rnd_lim_d            = rnd_lim_new;
            rail_o.crypt_d       = 1'b1;
            rail_o.dec_key_gen_d = rail_i.dec_key_gen;
          end
        end
      end

      // Initial round, key addition only
      INIT: begin
        rail_o.state_we   = 1'b1;
        rail_o.state_sel  = STATE_INIT;
        rail_o.add_rk_sel = ADD_RK_INIT;
        rnd_ctr_d         = rnd_ctr_q + 1'b1;
        state_d           = ROUND;
      end

      ROUND: begin
        rail_o.state_we   = 1'b1;
        rail_o.state_sel  = STATE_ROUND;
        rail_o.add_rk_sel = ADD_RK_ROUND;
        rnd_ctr_d         = rnd_ctr_q + 1'b1;
        if (rnd_ctr_q == rnd_last) begin
          state_d = FINISH;
        end
      end

      // Selectors hold while the output waits
      FINISH: begin
        rail_o.state_sel  = STATE_ROUND;
        rail_o.add_rk_sel = ADD_RK_FINAL;
        if (rail_i.dec_key_gen_q) begin
          // Final round key goes to the decryption key register
          rail_o.key_dec_we    = 1'b1;
          rail_o.crypt_d       = 1'b0;
          rail_o.dec_key_gen_d = 1'b0;
          rnd_ctr_d            = '0;
          state_d              = IDLE;
        end else begin
          rail_o.out_valid = 1'b1;
          if (rail_i.out_ready) begin
            rail_o.crypt_d       = 1'b0;
            rail_o.dec_key_gen_d = 1'b0;
            rnd_ctr_d            = '0;
            state_d              = IDLE;
          end
        end
      end

      // Terminal
      ERROR: begin
        rail_o.alert         = 1'b1;
        rail_o.crypt_d       = 1'b0;
        rail_o.dec_key_gen_d = 1'b0;
      end

      default: begin
        rail_o.alert = 1'b1;
        state_d      = ERROR;
      end
    endcase

    // A fault overrides the sequence and silences the strobes at once
    if (rail_i.err) begin
      state_d           = ERROR;
      rail_o.in_ready   = 1'b0;
      rail_o.out_valid  = 1'b0;
      rail_o.state_we   = 1'b0;
      rail_o.key_dec_we = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q   <= IDLE;
      rnd_ctr_q <= '0;
      rnd_lim_q <= Rounds128;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      rnd_lim_q <= rnd_lim_d;
    end
  end

endmodule

//--- src/cipher_round_ctrl.sv
// Cipher round controller top
`timescale 1ns/1ps

module cipher_round_ctrl import cipher_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Block handshake
  input  sp2v_e     in_valid_i,
  output sp2v_e     in_ready_o,
  output sp2v_e     out_valid_o,
  input  sp2v_e     out_ready_i,

  // Operation and status
  input  ciph_op_e  op_i,
  input  key_len_e  key_len_i,
  output sp2v_e     crypt_o,
  input  sp2v_e     dec_key_gen_i,
  output sp2v_e     dec_key_gen_o,
  input  logic      alert_fatal_i,

  // Data path and key path control
  output sp2v_e     state_we_o,
  output sp2v_e     key_dec_we_o,
  output ctrl_sel_t sel_o,
  output logic      alert_o
);

  rail_in_t  [NumRails-1:0] rails_in;
  rail_out_t [NumRails-1:0] rails_out;
  logic                     mismatch;

  ////////////////////
  // Feeder
  ////////////////////

  sp2v_chk u_sp2v_chk (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .in_valid_i      ( in_valid_i    ),
    .out_ready_i     ( out_ready_i   ),
    .crypt_q_i       ( crypt_o       ),  // Checked like an input
    .dec_key_gen_q_i ( dec_key_gen_o ),
    .dec_key_gen_i   ( dec_key_gen_i ),
    .op_i            ( op_i          ),
    .key_len_i       ( key_len_i     ),
    .mismatch_i      ( mismatch      ),
    .alert_fatal_i   ( alert_fatal_i ),
    .rails_o         ( rails_in      )
  );

  ////////////////////
  // Rails
  ////////////////////

  for (genvar i = 0; i < NumRails; i++) begin : gen_rail
    round_fsm u_round_fsm (
      .clk_i  ( clk_i        ),
      .rst_ni ( rst_ni       ),
      .rail_i ( rails_in[i]  ),
      .rail_o ( rails_out[i] )
    );
  end

  ////////////////////
  // Combiner
  ////////////////////

  rail_combine u_rail_combine (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .rails_i         ( rails_out     ),
    .op_i            ( op_i          ),
    .in_ready_o      ( in_ready_o    ),
    .out_valid_o     ( out_valid_o   ),
    .state_we_o      ( state_we_o    ),
    .key_dec_we_o    ( key_dec_we_o  ),
    .crypt_q_o       ( crypt_o       ),
    .dec_key_gen_q_o ( dec_key_gen_o ),
    .sel_o           ( sel_o         ),
    .alert_o         ( alert_o       ),
    .mismatch_o      ( mismatch      )
  );

endmodule

//--- src/rail_combine.sv
// Rail combiner and status registers
`timescale 1ns/1ps

module rail_combine import cipher_ctrl_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rail_out_t [NumRails-1:0] rails_i,
  input  ciph_op_e                 op_i,
  output sp2v_e                    in_ready_o,
  output sp2v_e                    out_valid_o,
  output sp2v_e                    state_we_o,
  output sp2v_e                    key_dec_we_o,
  output sp2v_e                    crypt_q_o,
  output sp2v_e                    dec_key_gen_q_o,
  output ctrl_sel_t                sel_o,
  output logic                     alert_o,
  output logic                     mismatch_o
);

  rail_out_t            comb;   // OR of all rails
  logic [Sp2VWidth-1:0] in_ready_raw;
  logic [Sp2VWidth-1:0] out_valid_raw;
  logic [Sp2VWidth-1:0] state_we_raw;
  logic [Sp2VWidth-1:0] key_dec_we_raw;
  logic [Sp2VWidth-1:0] crypt_raw;
  logic [Sp2VWidth-1:0] dec_key_gen_raw;
  sp2v_e                crypt_d;
  sp2v_e                crypt_q;
  sp2v_e                dec_key_gen_d;
  sp2v_e                dec_key_gen_q;

  // Any rail off the OR result is a disagreement
  always_comb begin : combine_rails
    comb       = '0;
    mismatch_o = 1'b0;
    for (int i = 0; i < NumRails; i++) begin
      comb = rail_out_t'(comb | rails_i[i]);
    end
    for (int i = 0; i < NumRails; i++) begin
      if (rails_i[i] != comb) begin
        mismatch_o = 1'b1;
      end
    end
  end

  // Each rail drives its own bit of the sparse outputs
  always_comb begin : reencode
    for (int unsigned i = 0; i < NumRails; i++) begin
      in_ready_raw[i]    = sp2v_rail_bit(rails_i[i].in_ready, i);
      out_valid_raw[i]   = sp2v_rail_bit(rails_i[i].out_valid, i);
      state_we_raw[i]    = sp2v_rail_bit(rails_i[i].state_we, i);
      key_dec_we_raw[i]  = sp2v_rail_bit(rails_i[i].key_dec_we, i);
      crypt_raw[i]       = sp2v_rail_bit(rails_i[i].crypt_d, i);
      dec_key_gen_raw[i] = sp2v_rail_bit(rails_i[i].dec_key_gen_d, i);
    end
  end

  assign in_ready_o    = sp2v_e'(in_ready_raw);
  assign out_valid_o   = sp2v_e'(out_valid_raw);
  assign state_we_o    = sp2v_e'(state_we_raw);
  assign key_dec_we_o  = sp2v_e'(key_dec_we_raw);
  assign crypt_d       = sp2v_e'(crypt_raw);
  assign dec_key_gen_d = sp2v_e'(dec_key_gen_raw);

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_status
    if (!rst_ni) begin
      crypt_q       <= SP2V_LOW;
      dec_key_gen_q <= SP2V_LOW;
    end else begin
      crypt_q       <= crypt_d;
      dec_key_gen_q <= dec_key_gen_d;
    end
  end

  assign crypt_q_o       = crypt_q;
  assign dec_key_gen_q_o = dec_key_gen_q;

  assign sel_o.state_sel        = comb.state_sel;
  assign sel_o.add_rk_sel       = comb.add_rk_sel;
  // Key generation always expands forward from acceptance on
  assign sel_o.key_expand_op    = (dec_key_gen_d == SP2V_HIGH || dec_key_gen_q == SP2V_HIGH) ?
                                  CIPH_FWD : op_i;
  assign sel_o.key_expand_round = comb.rnd_ctr;
  assign alert_o                = comb.alert;

endmodule

//--- src/sp2v_chk.sv
// Sparse input check and rail feeder
`timescale 1ns/1ps

module sp2v_chk import cipher_ctrl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  sp2v_e                   in_valid_i,
  input  sp2v_e                   out_ready_i,
  input  sp2v_e                   crypt_q_i,
  input  sp2v_e                   dec_key_gen_q_i,
  input  sp2v_e                   dec_key_gen_i,
  input  ciph_op_e                op_i,
  input  key_len_e                key_len_i,
  input  logic                    mismatch_i,     // Rail disagreement
  input  logic                    alert_fatal_i,
  output rail_in_t [NumRails-1:0] rails_o
);

  logic [NumSp2VIn-1:0][Sp2VWidth-1:0] sp_raw;
  logic                                enc_err;
  logic                                err_q;

  // Index 0 is in_valid
  assign sp_raw = {dec_key_gen_i, dec_key_gen_q_i, crypt_q_i, out_ready_i, in_valid_i};

  always_comb begin : check_enc
    enc_err = 1'b0;
    for (int s = 0; s < NumSp2VIn; s++) begin
      if (!(sp_raw[s] inside {SP2V_HIGH, SP2V_LOW})) begin
        enc_err = 1'b1;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_err
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_q | enc_err | mismatch_i | alert_fatal_i;
    end
  end

  // Rail i gets bit i of every level with its polarity undone
  always_comb begin : fan_out
    for (int unsigned i = 0; i < NumRails; i++) begin
      rails_o[i].in_valid      = sp2v_rail_bit(sp_raw[0][i], i);
      rails_o[i].out_ready     = sp2v_rail_bit(sp_raw[1][i], i);
      rails_o[i].crypt_q       = sp2v_rail_bit(sp_raw[2][i], i);
      rails_o[i].dec_key_gen_q = sp2v_rail_bit(sp_raw[3][i], i);
      rails_o[i].dec_key_gen   = sp2v_rail_bit(sp_raw[4][i], i);
      rails_o[i].op            = op_i;
      rails_o[i].key_len       = key_len_i;
      rails_o[i].err           = err_q;
    end
  end

endmodule

//--- tb/cipher_round_ctrl_chk.sv
// Round controller protocol checks
`timescale 1ns/1ps

module cipher_round_ctrl_chk import cipher_ctrl_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  sp2v_e out_valid_o,
  input  sp2v_e state_we_o,
  input  logic  alert_o
);

  ////////////////////
  // Output strobes
  ////////////////////

  // No result offered from a faulted controller
  valid_without_alert: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(out_valid_o == SP2V_HIGH && alert_o)
  ) else $error("out_valid_o and alert_o high together");

  // State register frozen while the result waits
  hold_while_waiting: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o == SP2V_HIGH) |-> (state_we_o == SP2V_LOW)
  ) else $error("state_we_o active while out_valid_o waits");

  ////////////////////
  // Alert
  ////////////////////

  alert_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o
  ) else $error("alert_o fell without a reset");

endmodule

//--- tb/cipher_round_ctrl_stim.txt
# op(1 fwd, 2 inv) key_bits dec_key_gen stall_cycles inject(0 none, 1 bad in_valid, 2 fatal)
# One operation per line, fault injections last
1 128 0 0 0
1 192 0 0 0
1 256 0 0 0
2 128 0 0 0
2 192 0 3 0
2 256 0 0 0
1 128 1 0 0
1 192 1 0 0
1 256 1 0 0
2 128 0 5 0
1 256 0 7 0
2 256 1 2 0
1 128 0 1 0
2 192 0 0 0
1 192 0 4 0
2 128 1 0 0
1 256 0 2 0
2 256 0 6 0
1 128 0 0 1
1 128 0 0 2

//--- tb/tb_cipher_round_ctrl.sv
// Round controller testbench
`timescale 1ns/1ps

module tb_cipher_round_ctrl import cipher_ctrl_pkg::*; ();

  logic        clk_i;
  logic        rst_ni;
  sp2v_e       in_valid_i;
  sp2v_e       in_ready_o;
  sp2v_e       out_valid_o;
  sp2v_e       out_ready_i;
  ciph_op_e    op_i;
  key_len_e    key_len_i;
  sp2v_e       crypt_o;
  sp2v_e       dec_key_gen_i;
  sp2v_e       dec_key_gen_o;
  logic        alert_fatal_i;
  sp2v_e       state_we_o;
  sp2v_e       key_dec_we_o;
  ctrl_sel_t   sel_o;
  logic        alert_o;

  int          op_q[$];      // One entry per stimulus line
  int          len_q[$];
  int          dkg_q[$];
  int          stall_q[$];
  int          inj_q[$];
  string       test_name;
  logic [31:0] rng_state = 32'd77;
  int unsigned limit_cycles = 0;

  cipher_round_ctrl UUT (.*);

  bind cipher_round_ctrl cipher_round_ctrl_chk u_chk (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .out_valid_o ( out_valid_o ),
    .state_we_o  ( state_we_o  ),
    .alert_o     ( alert_o     )
  );

  always #20 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int round_count(input int bits);
    case (bits)
      192:     return 12;
      256:     return 14;
      default: return 10;
    endcase
  endfunction

  function automatic key_len_e key_len_code(input int bits);
    case (bits)
      192:     return KEY_192;
      256:     return KEY_256;
      default: return KEY_128;
    endcase
  endfunction

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  // Full output picture of one cycle with alert expected low
  task automatic check_cycle(input sp2v_e rdy, input sp2v_e vld, input sp2v_e we,
                             input sp2v_e kdw, input sp2v_e cry, input sp2v_e dkg,
                             input state_sel_e ss, input add_rk_sel_e ark, input int rnd,
                             input ciph_op_e kop);
    check_val("in_ready_o", rdy, in_ready_o);
    check_val("out_valid_o", vld, out_valid_o);
    check_val("state_we_o", we, state_we_o);
    check_val("key_dec_we_o", kdw, key_dec_we_o);
    check_val("crypt_o", cry, crypt_o);
    check_val("dec_key_gen_o", dkg, dec_key_gen_o);
    check_val("state_sel", ss, sel_o.state_sel);
    check_val("add_rk_sel", ark, sel_o.add_rk_sel);
    check_val("key_expand_round", rnd, sel_o.key_expand_round);
    check_val("key_expand_op", kop, sel_o.key_expand_op);
    check_val("alert_o", 0, alert_o);
  endtask

  task automatic read_stim();
    int    fd;
    int    n;
    int    f[5];
    string line;
    fd = $fopen("tb/cipher_round_ctrl_stim.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the stimulus file");
      stop_on_error();
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() == 0 || line[0] == "#") continue;
      n = $sscanf(line, "%d %d %d %d %d", f[0], f[1], f[2], f[3], f[4]);
      if (n != 5) continue;   // Blank line
      op_q.push_back(f[0]);
      len_q.push_back(f[1]);
      dkg_q.push_back(f[2]);
      stall_q.push_back(f[3]);
      inj_q.push_back(f[4]);
      limit_cycles += round_count(f[1]) + f[3] + 10 + ((f[4] != 0) ? 8 : 0);
    end
    $fclose(fd);
    limit_cycles += 20;   // Initial reset and margin
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    @(negedge clk_i);
    check_cycle(SP2V_HIGH, SP2V_LOW, SP2V_LOW, SP2V_LOW, SP2V_LOW, SP2V_LOW,
                STATE_CLEAR, ADD_RK_INIT, 0, op_i);
    @(posedge clk_i);
    #2;
  endtask

  ////////////////////
  // Operations
  ////////////////////

  task automatic run_block(input int idx);
    int       n;
    int       stall;
    int       tries;
    logic     dkg;
    ciph_op_e op;
    ciph_op_e kop;
    sp2v_e    dkg_exp;
    op        = (op_q[idx] == 2) ? CIPH_INV : CIPH_FWD;
    n         = round_count(len_q[idx]);
    dkg       = (dkg_q[idx] != 0);
    kop       = dkg ? CIPH_FWD : op;   // Key generation expands forward
    dkg_exp   = dkg ? SP2V_HIGH : SP2V_LOW;
    rng_state = xorshift32(rng_state);
    stall     = stall_q[idx] + int'(rng_state[1:0]);
    test_name = $sformatf("blk%0d_%s_k%0d%s", idx, (op == CIPH_INV) ? "inv" : "fwd",
                          len_q[idx], dkg ? "_dkg" : "");
    op_i          = op;
    key_len_i     = key_len_code(len_q[idx]);
    dec_key_gen_i = dkg_exp;
    in_valid_i    = SP2V_HIGH;
    tries         = 0;
    @(negedge clk_i);
    while (in_ready_o != SP2V_HIGH) begin
      tries++;
      assert (tries < 4) else begin
        $display("%s: in_ready_o never rose for the block", test_name);
        stop_on_error();
      end
      @(posedge clk_i);
      @(negedge clk_i);
    end
    @(posedge clk_i);   // Acceptance edge
    #2;
    in_valid_i    = SP2V_LOW;
    dec_key_gen_i = SP2V_LOW;
    // Initial round then the middle rounds
    for (int j = 0; j < n; j++) begin
      @(negedge clk_i);
      check_cycle(SP2V_LOW, SP2V_LOW, SP2V_HIGH, SP2V_LOW, SP2V_HIGH, dkg_exp,
                  (j == 0) ? STATE_INIT : STATE_ROUND, (j == 0) ? ADD_RK_INIT : ADD_RK_ROUND,
                  j, kop);
      @(posedge clk_i);
      #2;
    end
    if (dkg) begin
      @(negedge clk_i);
      check_cycle(SP2V_LOW, SP2V_LOW, SP2V_LOW, SP2V_HIGH, SP2V_HIGH, SP2V_HIGH,
                  STATE_ROUND, ADD_RK_FINAL, n, CIPH_FWD);
      @(posedge clk_i);
      #2;
    end else begin
      for (int s = 0; s <= stall; s++) begin
        out_ready_i = (s == stall) ? SP2V_HIGH : SP2V_LOW;
        @(negedge clk_i);
        check_cycle(SP2V_LOW, SP2V_HIGH, SP2V_LOW, SP2V_LOW, SP2V_HIGH, SP2V_LOW,
                    STATE_ROUND, ADD_RK_FINAL, n, op);
        @(posedge clk_i);
        #2;
      end
      out_ready_i = SP2V_LOW;
    end
    @(negedge clk_i);   // Back in IDLE
    check_cycle(SP2V_HIGH, SP2V_LOW, SP2V_LOW, SP2V_LOW, SP2V_LOW, SP2V_LOW,
                STATE_CLEAR, ADD_RK_INIT, 0, op);
    @(posedge clk_i);
    #2;
  endtask

  task automatic inject_fault(input int idx);
    logic seen;
    test_name = (inj_q[idx] == 1) ? "fault_bad_in_valid" : "fault_alert_input";
    if (inj_q[idx] == 1) begin
      in_valid_i = sp2v_e'(2'b11);
    end else begin
      alert_fatal_i = 1'b1;
    end
    @(posedge clk_i);
    #2;
    in_valid_i    = SP2V_LOW;
    alert_fatal_i = 1'b0;
    @(negedge clk_i);
    check_val("in_ready_o", SP2V_LOW, in_ready_o);
    check_val("out_valid_o", SP2V_LOW, out_valid_o);
    seen = alert_o;
    for (int c = 0; c < 2 && !seen; c++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      seen = alert_o;
    end
    assert (seen) else begin
      $display("%s: alert_o did not rise within two cycles of the fault", test_name);
      stop_on_error();
    end
    // Strobes stay dead even with a block offered
    repeat (6) begin
      @(posedge clk_i);
      #2;
      in_valid_i  = SP2V_HIGH;
      out_ready_i = SP2V_HIGH;
      @(negedge clk_i);
      check_val("alert_o", 1, alert_o);
      check_val("in_ready_o", SP2V_LOW, in_ready_o);
      check_val("out_valid_o", SP2V_LOW, out_valid_o);
    end
    @(posedge clk_i);
    #2;
    in_valid_i  = SP2V_LOW;
    out_ready_i = SP2V_LOW;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    in_valid_i    = SP2V_LOW;
    out_ready_i   = SP2V_LOW;
    dec_key_gen_i = SP2V_LOW;
    op_i          = CIPH_FWD;
    key_len_i     = KEY_128;
    alert_fatal_i = 1'b0;
    test_name     = "reset";
    read_stim();
    apply_reset();
    for (int i = 0; i < op_q.size(); i++) begin
      if (inj_q[i] == 0) begin
        run_block(i);
      end else begin
        inject_fault(i);
        if (i < op_q.size() - 1) begin
          test_name = "reset";
          apply_reset();
        end
      end
    end
    $display("TEST PASSED");
    $finish;
  end

  // Budget follows the stimulus length
  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles during %s", limit_cycles, test_name);
    stop_on_error();
  end

endmodule
